// ==== ifp_defines.svh ====
////////////////////
// Widths and breakage-monitor constants for the TMR IF/ID stage
// Included by the package and by every module that sizes its ports
////////////////////

`ifndef IFP_DEFINES_SVH
`define IFP_DEFINES_SVH

// Datapath widths
`define IFP_XLEN 32

// Two XLEN fields plus five flag bits
`define IFP_WORD_W (2 * `IFP_XLEN + 5)

`define IFP_NREP 3

////////////////////
// Breakage monitor
////////////////////
`define IFP_INCREMENT 4
`define IFP_DECREMENT 1
`define IFP_BREAK_THRESHOLD 16
`define IFP_COUNT_W 6

`endif

// ==== ifp_pkg.sv ====
////////////////////
// Types shared by the TMR IF/ID stage
// Holds the packed stage word, its field positions and the monitor states
// Import with a wildcard in the module header
////////////////////

`include "ifp_defines.svh"

package ifp_pkg;

        // One replica's decode-side outputs packed for voting
        typedef logic [`IFP_WORD_W-1:0] stage_word_t;

        ////////////////////
        // Field positions, low bit of each field
        ////////////////////
        localparam int unsigned POS_IF_VALID      = 0;
        localparam int unsigned POS_ILLEGAL_C     = 1;
        localparam int unsigned POS_COMPRESSED    = 2;
        localparam int unsigned POS_PC            = 3;
        localparam int unsigned POS_FETCH_FAILED  = POS_PC + `IFP_XLEN;
        localparam int unsigned POS_RDATA         = POS_FETCH_FAILED + 1;
        localparam int unsigned POS_INSTR_VALID   = POS_RDATA + `IFP_XLEN;

        // Breakage monitor state, broken is sticky until reset
        typedef enum logic {
                MON_HEALTHY = 1'b0,
                MON_BROKEN  = 1'b1
        } mon_state_e;

endpackage

// ==== if_id_stage.sv ====
////////////////////
// One replica of the IF/ID pipeline register
// Captures the decoded instruction when fetch is valid and decode accepts
// Three of these feed the TMR voter in the top level
////////////////////

`include "ifp_defines.svh"

module if_id_stage (
        input  logic                 clk_i,
        input  logic                 arst_n_i,

        // Fetch side
        input  logic [`IFP_XLEN-1:0] instr_decompressed_i,
        input  logic                 instr_compressed_i,
        input  logic                 illegal_c_insn_i,
        input  logic [`IFP_XLEN-1:0] pc_if_i,
        input  logic                 fetch_failed_i,
        input  logic                 fetch_valid_i,

        // Flow control
        input  logic                 id_ready_i,
        input  logic                 halt_if_i,
        input  logic                 instr_valid_i,
        input  logic                 clear_instr_valid_i,

        // Decode side
        output logic                 instr_valid_id_o,
        output logic [`IFP_XLEN-1:0] instr_rdata_id_o,
        output logic                 is_fetch_failed_o,
        output logic [`IFP_XLEN-1:0] pc_id_o,
        output logic                 is_compressed_id_o,
        output logic                 illegal_c_insn_id_o,
        output logic                 if_valid_o
);

        logic capture;

        // Stage hands over only when ID is ready and fetch is not halted
        assign if_valid_o = fetch_valid_i & id_ready_i & ~halt_if_i;
        assign capture    = if_valid_o & instr_valid_i;

        ////////////////////
        // IF/ID register
        ////////////////////
        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        instr_valid_id_o    <= 1'b0;
                        instr_rdata_id_o    <= '0;
                        is_fetch_failed_o   <= 1'b0;
                        pc_id_o             <= '0;
                        is_compressed_id_o  <= 1'b0;
                        illegal_c_insn_id_o <= 1'b0;
                end else if (capture) begin
                        instr_valid_id_o    <= 1'b1;
                        instr_rdata_id_o    <= instr_decompressed_i;
                        is_fetch_failed_o   <= fetch_failed_i;
                        pc_id_o             <= pc_if_i;
                        is_compressed_id_o  <= instr_compressed_i;
                        illegal_c_insn_id_o <= illegal_c_insn_i;
                end else if (clear_instr_valid_i) begin
                        // Only valid drops, payload stays for the decoder
                        instr_valid_id_o    <= 1'b0;
                end
        end

endmodule

// ==== tmr_voter.sv ====
////////////////////
// Bitwise majority voter over three packed stage words
// Broken replicas are left out and the lowest healthy one is passed on
// Reports per-replica mismatch and the global detect and correct flags
////////////////////

`include "ifp_defines.svh"

module tmr_voter
        import ifp_pkg::*;
(
        input  stage_word_t [`IFP_NREP-1:0] rep_word_i,
        input  logic [`IFP_NREP-1:0]        broken_i,

        output stage_word_t                 voted_o,
        output logic [`IFP_NREP-1:0]        block_err_o,
        output logic                        err_detected_o,
        output logic                        err_corrected_o
);

        localparam int SEL_W = $clog2(`IFP_NREP);

        stage_word_t        majority;
        logic [SEL_W-1:0]   sel;
        logic               any_broken;

        assign any_broken = |broken_i;

        // Two out of three on every bit
        assign majority = (rep_word_i[0] & rep_word_i[1])
                        | (rep_word_i[0] & rep_word_i[2])
                        | (rep_word_i[1] & rep_word_i[2]);

        ////////////////////
        // Fallback selection
        ////////////////////

        // Walk down so the last hit is the lowest healthy index,
        // replica 0 stays selected when every replica is broken
        always_comb begin
                sel = '0;
                for (int k = `IFP_NREP - 1; k >= 0; k--) begin
                        if (!broken_i[k]) begin
                                sel = SEL_W'(k);
                        end
                end
        end

        assign voted_o = any_broken ? rep_word_i[sel] : majority;

        ////////////////////
        // Error reporting
        ////////////////////

        // A retired replica never raises its own error
        always_comb begin
                for (int k = 0; k < `IFP_NREP; k++) begin
                        block_err_o[k] = !broken_i[k] && (rep_word_i[k] != voted_o);
                end
        end

        assign err_detected_o  = |block_err_o;

        // Correction is only trusted while all three replicas take part
        assign err_corrected_o = err_detected_o & ~any_broken;

endmodule

// ==== breakage_monitor.sv ====
////////////////////
// Fault counter for one replica
// Adds on every error cycle, drains slowly otherwise, both saturating
// Marks the replica broken at the threshold or when forced, until reset
////////////////////

`include "ifp_defines.svh"

module breakage_monitor
        import ifp_pkg::*;
(
        input  logic clk_i,
        input  logic arst_n_i,
        input  logic err_detected_i,
        input  logic set_broken_i,
        output logic is_broken_o
);

        localparam logic [`IFP_COUNT_W:0]   CNT_MAX = (1 << `IFP_COUNT_W) - 1;
        localparam logic [`IFP_COUNT_W:0]   INC     = `IFP_INCREMENT;
        localparam logic [`IFP_COUNT_W-1:0] DEC     = `IFP_DECREMENT;
        localparam logic [`IFP_COUNT_W-1:0] THRESH  = `IFP_BREAK_THRESHOLD;

        logic [`IFP_COUNT_W-1:0] count_q, count_d;
        logic [`IFP_COUNT_W:0]   count_inc;
        mon_state_e              state_q, state_d;

        // Extra bit catches the overflow before the cap
        assign count_inc = {1'b0, count_q} + INC;

        always_comb begin
                if (err_detected_i) begin
                        if (count_inc > CNT_MAX) begin
                                count_d = CNT_MAX[`IFP_COUNT_W-1:0];
                        end else begin
                                count_d = count_inc[`IFP_COUNT_W-1:0];
                        end
                end else if (count_q >= DEC) begin
                        count_d = count_q - DEC;
                end else begin
                        count_d = '0;
                end

                // Threshold is judged on the updated count
                state_d = state_q;
                if (set_broken_i || (count_d >= THRESH)) begin
                        state_d = MON_BROKEN;
                end
        end

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        count_q <= '0;
                        state_q <= MON_HEALTHY;
                end else begin
                        count_q <= count_d;
                        state_q <= state_d;
                end
        end

        assign is_broken_o = (state_q == MON_BROKEN);

endmodule

// ==== if_pipeline_tmr.sv ====
////////////////////
// Triple-redundant IF/ID pipeline register
// Each replica takes its own copy of the fetch inputs, the voter merges
// the three packed words and the monitors retire a failing replica
////////////////////

`include "ifp_defines.svh"

module if_pipeline_tmr
        import ifp_pkg::*;
(
        input  logic                                clk_i,
        input  logic                                arst_n_i,

        // Replicated fetch side, one slice per replica
        input  logic [`IFP_NREP-1:0][`IFP_XLEN-1:0] instr_decompressed_i,
        input  logic [`IFP_NREP-1:0]                instr_compressed_i,
        input  logic [`IFP_NREP-1:0]                illegal_c_insn_i,
        input  logic [`IFP_NREP-1:0][`IFP_XLEN-1:0] pc_if_i,
        input  logic [`IFP_NREP-1:0]                fetch_failed_i,
        input  logic [`IFP_NREP-1:0]                fetch_valid_i,
        input  logic [`IFP_NREP-1:0]                id_ready_i,
        input  logic [`IFP_NREP-1:0]                halt_if_i,
        input  logic [`IFP_NREP-1:0]                instr_valid_i,
        input  logic [`IFP_NREP-1:0]                clear_instr_valid_i,
        input  logic [`IFP_NREP-1:0]                set_broken_i,

        // Voted decode side
        output logic                                instr_valid_id_o,
        output logic [`IFP_XLEN-1:0]                instr_rdata_id_o,
        output logic                                is_fetch_failed_o,
        output logic [`IFP_XLEN-1:0]                pc_id_o,
        output logic                                is_compressed_id_o,
        output logic                                illegal_c_insn_id_o,
        output logic                                if_valid_o,

        // Fault status
        output logic [`IFP_NREP-1:0]                is_broken_o,
        output logic                                err_detected_o,
        output logic                                err_corrected_o
);

        stage_word_t [`IFP_NREP-1:0] rep_word;
        stage_word_t                 voted_word;
        logic [`IFP_NREP-1:0]        block_err;

        ////////////////////
        // Replicas and monitors
        ////////////////////
        for (genvar k = 0; k < `IFP_NREP; k++) begin : g_rep
                if_id_stage u_stage (
                        .clk_i               (clk_i),
                        .arst_n_i            (arst_n_i),
                        .instr_decompressed_i(instr_decompressed_i[k]),
                        .instr_compressed_i  (instr_compressed_i[k]),
                        .illegal_c_insn_i    (illegal_c_insn_i[k]),
                        .pc_if_i             (pc_if_i[k]),
                        .fetch_failed_i      (fetch_failed_i[k]),
                        .fetch_valid_i       (fetch_valid_i[k]),
                        .id_ready_i          (id_ready_i[k]),
                        .halt_if_i           (halt_if_i[k]),
                        .instr_valid_i       (instr_valid_i[k]),
                        .clear_instr_valid_i (clear_instr_valid_i[k]),
                        .instr_valid_id_o    (rep_word[k][POS_INSTR_VALID]),
                        .instr_rdata_id_o    (rep_word[k][POS_RDATA +: `IFP_XLEN]),
                        .is_fetch_failed_o   (rep_word[k][POS_FETCH_FAILED]),
                        .pc_id_o             (rep_word[k][POS_PC +: `IFP_XLEN]),
                        .is_compressed_id_o  (rep_word[k][POS_COMPRESSED]),
                        .illegal_c_insn_id_o (rep_word[k][POS_ILLEGAL_C]),
                        .if_valid_o          (rep_word[k][POS_IF_VALID])
                );

                // Block error of this replica drives its own counter
                breakage_monitor u_monitor (
                        .clk_i         (clk_i),
                        .arst_n_i      (arst_n_i),
                        .err_detected_i(block_err[k]),
                        .set_broken_i  (set_broken_i[k]),
                        .is_broken_o   (is_broken_o[k])
                );
        end

        ////////////////////
        // Voting
        ////////////////////
        tmr_voter u_voter (
                .rep_word_i     (rep_word),
                .broken_i       (is_broken_o),
                .voted_o        (voted_word),
                .block_err_o    (block_err),
                .err_detected_o (err_detected_o),
                .err_corrected_o(err_corrected_o)
        );

        // Unpack the voted word onto the decode-side ports
        assign instr_valid_id_o    = voted_word[POS_INSTR_VALID];
        assign instr_rdata_id_o    = voted_word[POS_RDATA +: `IFP_XLEN];
        assign is_fetch_failed_o   = voted_word[POS_FETCH_FAILED];
        assign pc_id_o             = voted_word[POS_PC +: `IFP_XLEN];
        assign is_compressed_id_o  = voted_word[POS_COMPRESSED];
        assign illegal_c_insn_id_o = voted_word[POS_ILLEGAL_C];
        assign if_valid_o          = voted_word[POS_IF_VALID];

endmodule

// ==== if_pipeline_tmr_chk.sv ====
////////////////////
// Concurrent assertions on the TMR IF/ID top level
// Bound into every if_pipeline_tmr instance
////////////////////

`include "ifp_defines.svh"

module if_pipeline_tmr_chk (
        input logic                 clk_i,
        input logic                 arst_n_i,
        input logic                 instr_valid_id_i,
        input logic [`IFP_NREP-1:0] is_broken_i,
        input logic                 err_detected_i,
        input logic                 err_corrected_i
);

        // A retired replica stays retired until reset
        broken_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                (is_broken_i & $past(is_broken_i)) == $past(is_broken_i))
                else $error("is_broken_o bit fell without reset");

        corrected_implies_detected: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                err_corrected_i |-> err_detected_i)
                else $error("err_corrected_o high without err_detected_o");

        // Nothing can have been captured yet in the first cycle out of reset
        valid_low_after_reset: assert property (@(posedge clk_i)
                $rose(arst_n_i) |-> !instr_valid_id_i)
                else $error("instr_valid_id_o high right after reset release");

endmodule

bind if_pipeline_tmr if_pipeline_tmr_chk u_chk (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .instr_valid_id_i(instr_valid_id_o),
        .is_broken_i     (is_broken_o),
        .err_detected_i  (err_detected_o),
        .err_corrected_i (err_corrected_o)
);

// ==== tb_if_pipeline_tmr.sv ====
////////////////////
// Testbench for the triple-redundant IF/ID register
// Models each replica and its breakage counter, votes the model words
// with a reference function and compares the DUT at every falling edge
////////////////////

`include "ifp_defines.svh"

module tb_if_pipeline_tmr
        import ifp_pkg::*;
();

        // Five directed tests take under 50 cycles including reset
        localparam int MAX_CYCLES = 400;
        localparam int CNT_MAX    = (1 << `IFP_COUNT_W) - 1;

        logic                                clk_i;
        logic                                arst_n_i;
        logic [`IFP_NREP-1:0][`IFP_XLEN-1:0] instr_decompressed_i;
        logic [`IFP_NREP-1:0][`IFP_XLEN-1:0] pc_if_i;
        logic [`IFP_NREP-1:0]                instr_compressed_i, illegal_c_insn_i;
        logic [`IFP_NREP-1:0]                fetch_failed_i, fetch_valid_i;
        logic [`IFP_NREP-1:0]                id_ready_i, halt_if_i, instr_valid_i;
        logic [`IFP_NREP-1:0]                clear_instr_valid_i, set_broken_i;
        logic                                instr_valid_id_o, is_fetch_failed_o, if_valid_o;
        logic [`IFP_XLEN-1:0]                instr_rdata_id_o, pc_id_o;
        logic                                is_compressed_id_o, illegal_c_insn_id_o;
        logic [`IFP_NREP-1:0]                is_broken_o;
        logic                                err_detected_o, err_corrected_o;

        // Registered part of each replica without if_valid
        stage_word_t [`IFP_NREP-1:0] model_q;
        int                          count_q [`IFP_NREP];
        logic [`IFP_NREP-1:0]        broken_q;

        integer seed = 32'h9d;
        int     errors = 0;
        int     checks = 0;
        int     tests = 0;
        int     test_start = 0;
        int     cycles = 0;

        if_pipeline_tmr u_if_pipeline_tmr (.*);

        initial begin
                clk_i = 1'b0;
                forever #2 clk_i = ~clk_i;
        end

        ////////////////////
        // Reference model
        ////////////////////

        // Expected voter result from the majority and fallback rule
        function automatic void vote_ref(
                input  stage_word_t [`IFP_NREP-1:0] w,
                input  logic [`IFP_NREP-1:0]        broken,
                output stage_word_t                 voted,
                output logic [`IFP_NREP-1:0]        berr,
                output logic                        det,
                output logic                        cor
        );
                int ones;
                int pick;
                for (int b = 0; b < `IFP_WORD_W; b++) begin
                        ones = 0;
                        for (int k = 0; k < `IFP_NREP; k++) begin
                                ones += w[k][b];
                        end
                        voted[b] = (ones * 2 > `IFP_NREP);
                end
                pick = -1;
                for (int k = 0; k < `IFP_NREP; k++) begin
                        if (pick < 0 && !broken[k]) begin
                                pick = k;
                        end
                end
                if (broken != '0) begin
                        voted = (pick < 0) ? w[0] : w[pick];
                end
                det = 1'b0;
                for (int k = 0; k < `IFP_NREP; k++) begin
                        berr[k] = !broken[k] && (w[k] != voted);
                        det     = det | berr[k];
                end
                cor = det && (broken == '0);
        endfunction

        // Replica register after the next edge, by the flow rule
        function automatic stage_word_t stage_next(input stage_word_t q, input int k);
                stage_word_t d;
                d = q;
                if (fetch_valid_i[k] && id_ready_i[k] && !halt_if_i[k] && instr_valid_i[k]) begin
                        d[POS_INSTR_VALID]           = 1'b1;
                        d[POS_RDATA +: `IFP_XLEN]    = instr_decompressed_i[k];
                        d[POS_FETCH_FAILED]          = fetch_failed_i[k];
                        d[POS_PC +: `IFP_XLEN]       = pc_if_i[k];
                        d[POS_COMPRESSED]            = instr_compressed_i[k];
                        d[POS_ILLEGAL_C]             = illegal_c_insn_i[k];
                end else if (clear_instr_valid_i[k]) begin
                        d[POS_INSTR_VALID] = 1'b0;
                end
                return d;
        endfunction

        task automatic report_mismatch(input string name, input logic [`IFP_XLEN-1:0] exp_v,
                                       input logic [`IFP_XLEN-1:0] act_v);
                errors++;
                $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
        endtask

        ////////////////////
        // Compare process
        ////////////////////
        always @(negedge clk_i) begin : compare_outputs
                stage_word_t [`IFP_NREP-1:0] w;
                stage_word_t                 exp_w;
                logic [`IFP_NREP-1:0]        exp_berr;
                logic                        exp_det, exp_cor;
                if (!arst_n_i) begin
                        model_q  = '0;
                        broken_q = '0;
                        for (int k = 0; k < `IFP_NREP; k++) begin
                                count_q[k] = 0;
                        end
                end else begin
                        for (int k = 0; k < `IFP_NREP; k++) begin
                                w[k] = model_q[k];
                                w[k][POS_IF_VALID] = fetch_valid_i[k] & id_ready_i[k]
                                                     & ~halt_if_i[k];
                        end
                        vote_ref(w, broken_q, exp_w, exp_berr, exp_det, exp_cor);
                        checks++;
                        if (instr_valid_id_o !== exp_w[POS_INSTR_VALID])
                                report_mismatch("instr_valid_id_o", exp_w[POS_INSTR_VALID],
                                                instr_valid_id_o);
                        if (instr_rdata_id_o !== exp_w[POS_RDATA +: `IFP_XLEN])
                                report_mismatch("instr_rdata_id_o", exp_w[POS_RDATA +: `IFP_XLEN],
                                                instr_rdata_id_o);
                        if (is_fetch_failed_o !== exp_w[POS_FETCH_FAILED])
                                report_mismatch("is_fetch_failed_o", exp_w[POS_FETCH_FAILED],
                                                is_fetch_failed_o);
                        if (pc_id_o !== exp_w[POS_PC +: `IFP_XLEN])
                                report_mismatch("pc_id_o", exp_w[POS_PC +: `IFP_XLEN], pc_id_o);
                        if (is_compressed_id_o !== exp_w[POS_COMPRESSED])
                                report_mismatch("is_compressed_id_o", exp_w[POS_COMPRESSED],
                                                is_compressed_id_o);
                        if (illegal_c_insn_id_o !== exp_w[POS_ILLEGAL_C])
                                report_mismatch("illegal_c_insn_id_o", exp_w[POS_ILLEGAL_C],
                                                illegal_c_insn_id_o);
                        if (if_valid_o !== exp_w[POS_IF_VALID])
                                report_mismatch("if_valid_o", exp_w[POS_IF_VALID], if_valid_o);
                        if (is_broken_o !== broken_q)
                                report_mismatch("is_broken_o", broken_q, is_broken_o);
                        if (err_detected_o !== exp_det)
                                report_mismatch("err_detected_o", exp_det, err_detected_o);
                        if (err_corrected_o !== exp_cor)
                                report_mismatch("err_corrected_o", exp_cor, err_corrected_o);

                        // Advance replicas and monitors to the state after the next edge
                        for (int k = 0; k < `IFP_NREP; k++) begin
                                model_q[k] = stage_next(model_q[k], k);
                                if (exp_berr[k]) begin
                                        count_q[k] = count_q[k] + `IFP_INCREMENT;
                                        if (count_q[k] > CNT_MAX) count_q[k] = CNT_MAX;
                                end else begin
                                        count_q[k] = count_q[k] - `IFP_DECREMENT;
                                        if (count_q[k] < 0) count_q[k] = 0;
                                end
                                if (set_broken_i[k] || count_q[k] >= `IFP_BREAK_THRESHOLD)
                                        broken_q[k] = 1'b1;
                        end
                end
        end

        always @(posedge clk_i) begin
                cycles++;
                if (cycles >= MAX_CYCLES) begin
                        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                        $display("CHECKS FAILED");
                        $finish;
                end
        end

        ////////////////////
        // Stimulus
        ////////////////////
        task automatic drive_equal(input logic [`IFP_XLEN-1:0] instr,
                                   input logic [`IFP_XLEN-1:0] pc,
                                   input logic iv, input logic rdy, input logic halt,
                                   input logic clr);
                for (int k = 0; k < `IFP_NREP; k++) begin
                        instr_decompressed_i[k] = instr;
                        pc_if_i[k]              = pc;
                        instr_compressed_i[k]   = (instr[1:0] != 2'b11);
                        illegal_c_insn_i[k]     = instr[7];
                        fetch_failed_i[k]       = pc[2];
                        fetch_valid_i[k]        = 1'b1;
                        id_ready_i[k]           = rdy;
                        halt_if_i[k]            = halt;
                        instr_valid_i[k]        = iv;
                        clear_instr_valid_i[k]  = clr;
                end
                set_broken_i = '0;
        endtask

        task automatic next_cycle();
                @(posedge clk_i);
                #1;
        endtask

        task automatic finish_test(input string name);
                tests++;
                $display("Test %0d %s: %0d errors", tests, name, errors - test_start);
                test_start = errors;
        endtask

        initial begin : run_tests
                logic [`IFP_XLEN-1:0] instr;
                logic [`IFP_XLEN-1:0] pc;
                arst_n_i = 1'b0;
                drive_equal('0, '0, 1'b0, 1'b1, 1'b0, 1'b0);
                repeat (4) @(posedge clk_i);
                #1;
                arst_n_i = 1'b1;

                // Capture, then hold under back-pressure and halt, then clear
                instr = $random(seed);
                pc    = $random(seed);
                drive_equal(instr, pc, 1'b1, 1'b1, 1'b0, 1'b0);
                next_cycle();
                if (instr_rdata_id_o !== instr)
                        report_mismatch("instr_rdata_id_o", instr, instr_rdata_id_o);
                drive_equal($random(seed), $random(seed), 1'b1, 1'b0, 1'b0, 1'b0);
                next_cycle();
                drive_equal($random(seed), $random(seed), 1'b1, 1'b1, 1'b1, 1'b0);
                next_cycle();
                if (pc_id_o !== pc) report_mismatch("pc_id_o", pc, pc_id_o);
                drive_equal($random(seed), $random(seed), 1'b0, 1'b1, 1'b0, 1'b1);
                next_cycle();
                if (instr_valid_id_o !== 1'b0)
                        report_mismatch("instr_valid_id_o", 0, instr_valid_id_o);
                if (pc_id_o !== pc) report_mismatch("pc_id_o", pc, pc_id_o);
                finish_test("capture, hold and clear");

                // Instruction fault on replica 1, then pc fault on replica 0
                instr = $random(seed);
                pc    = $random(seed);
                drive_equal(instr, pc, 1'b1, 1'b1, 1'b0, 1'b0);
                instr_decompressed_i[1] = ~instr;
                next_cycle();
                if (err_corrected_o !== 1'b1)
                        report_mismatch("err_corrected_o", 1, err_corrected_o);
                drive_equal(instr, pc, 1'b1, 1'b1, 1'b0, 1'b0);
                pc_if_i[0] = pc ^ 32'h40;
                next_cycle();
                if (pc_id_o !== pc) report_mismatch("pc_id_o", pc, pc_id_o);
                drive_equal(instr, pc, 1'b1, 1'b1, 1'b0, 1'b0);
                next_cycle();
                finish_test("single replica fault");

                // Fault pattern E E C E E C peaks at 15 and ends at 14
                for (int i = 0; i < 6; i++) begin
                        drive_equal(instr, pc, 1'b0, 1'b1, 1'b0, 1'b0);
                        if (i % 3 != 2) fetch_valid_i[2] = 1'b0;
                        next_cycle();
                end
                drive_equal(instr, pc, 1'b0, 1'b1, 1'b0, 1'b0);
                repeat (16) next_cycle();
                for (int i = 0; i < 4; i++) begin
                        if (is_broken_o[2] !== 1'b0)
                                report_mismatch("is_broken_o[2]", 0, is_broken_o[2]);
                        fetch_valid_i[2] = 1'b0;
                        next_cycle();
                end
                fetch_valid_i[2] = 1'b1;
                if (is_broken_o[2] !== 1'b1) report_mismatch("is_broken_o[2]", 1, is_broken_o[2]);
                finish_test("breakage counter");

                // Replica 2 retired, then replica 0 stands alone against 1 and 2
                drive_equal(instr, pc, 1'b1, 1'b1, 1'b0, 1'b0);
                instr_decompressed_i[2] = ~instr;
                next_cycle();
                drive_equal(instr ^ 32'h10, pc, 1'b1, 1'b1, 1'b0, 1'b0);
                instr_decompressed_i[1] = instr;
                instr_decompressed_i[2] = instr;
                next_cycle();
                if (instr_rdata_id_o !== (instr ^ 32'h10))
                        report_mismatch("instr_rdata_id_o", instr ^ 32'h10, instr_rdata_id_o);
                if (err_detected_o !== 1'b1) report_mismatch("err_detected_o", 1, err_detected_o);
                drive_equal(instr, pc, 1'b0, 1'b1, 1'b0, 1'b0);
                next_cycle();
                finish_test("retired replica");

                // Forced break on replica 1, then a reset clears everything
                set_broken_i[1] = 1'b1;
                next_cycle();
                set_broken_i[1] = 1'b0;
                if (is_broken_o[1] !== 1'b1) report_mismatch("is_broken_o[1]", 1, is_broken_o[1]);
                arst_n_i = 1'b0;
                repeat (4) next_cycle();
                if (is_broken_o !== '0) report_mismatch("is_broken_o", 0, is_broken_o);
                if (pc_id_o !== '0) report_mismatch("pc_id_o", 0, pc_id_o);
                arst_n_i = 1'b1;
                repeat (2) next_cycle();
                finish_test("forced break and reset");

                $display("Tests %0d, cycles checked %0d, errors %0d", tests, checks, errors);
                if (errors == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule

// ==== verilog.f ====
+incdir+.
ifp_pkg.sv
if_id_stage.sv
tmr_voter.sv
breakage_monitor.sv
if_pipeline_tmr.sv
if_pipeline_tmr_chk.sv
tb_if_pipeline_tmr.sv

// ==== Bender.yml ====
package:
  name: if_pipeline_tmr

sources:
  - include_dirs:
      - .
    files:
      - ifp_pkg.sv
      - if_id_stage.sv
      - tmr_voter.sv
      - breakage_monitor.sv
      - if_pipeline_tmr.sv
  - target: test
    include_dirs:
      - .
    files:
      - if_pipeline_tmr_chk.sv
      - tb_if_pipeline_tmr.sv
